/* all.f */
+incdir+hw
hw/image_proc_pkg.sv
hw/proc_fsm.sv
hw/pixel_scanner.sv
hw/block_stats.sv
hw/pixel_writer.sv
hw/image_proc_top.sv
tests/image_checker.sv
tests/tb_image_proc.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
        --top-module tb_image_proc -Mdir obj_dir -o sim_image_proc -f all.f

./obj_dir/sim_image_proc > sim.log 2>&1
cat sim.log

if grep -qx "Test passed" sim.log; then
        exit 0
else
        echo "run.sh: simulation did not report success"
        exit 1
fi

/* tests/tb_image_proc.sv */
`timescale 1ns/1ps
`include "image_proc_defs.svh"

module tb_image_proc;
        import image_proc_pkg::*;

        // bound on the whole run, the checker has tighter bounds per phase
        localparam int run_limit = 25000;

        logic        clk;
        logic        rst_n;
        rgb_t        in_pix;
        coord_t      row;
        coord_t      col;
        logic        out_we;
        rgb_t        out_pix;
        logic        gray_done;
        logic        compress_done;
        logic        finished;
        logic        timed_out;
        int          value_errors;
        int          protocol_errors;
        int          wait_cycles;
        integer      seed;
        logic [31:0] rnd;
        logic        uniform;
        rgb_t        blk_val;

        // external image memory, read combinationally at row and col
        rgb_t mem [0:`IMG_DIM-1][0:`IMG_DIM-1];

        assign in_pix = mem[row][col];

        image_proc_top i_image_proc_top (
                .clk           (clk),
                .rst_n         (rst_n),
                .in_pix        (in_pix),
                .row           (row),
                .col           (col),
                .out_we        (out_we),
                .out_pix       (out_pix),
                .gray_done     (gray_done),
                .compress_done (compress_done)
        );

        image_checker i_image_checker (
                .clk             (clk),
                .rst_n           (rst_n),
                .row             (row),
                .col             (col),
                .out_we          (out_we),
                .out_pix         (out_pix),
                .gray_done       (gray_done),
                .compress_done   (compress_done),
                .finished        (finished),
                .timed_out       (timed_out),
                .value_errors    (value_errors),
                .protocol_errors (protocol_errors)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // reset is held for four rising edges and released on the fourth
        initial begin
                rst_n = 1'b0;
                repeat (4) @(posedge clk);
                rst_n <= 1'b1;
        end

        // memory model, filled with random pixels and then written by the DUT
        initial begin
                seed = 28261;
                for (int br = 0; br < `IMG_DIM; br += `BLK_DIM) begin
                        for (int bc = 0; bc < `IMG_DIM; bc += `BLK_DIM) begin
                                // about one block in eight gets a single color, so beta is 16
                                rnd     = $random(seed);
                                uniform = (rnd[2:0] == 3'd0);
                                rnd     = $random(seed);
                                blk_val = rnd[23:0];
                                for (int i = 0; i < `BLK_PIX; i++) begin
                                        rnd = $random(seed);
                                        mem[br + i / `BLK_DIM][bc + i % `BLK_DIM] <=
                                                uniform ? blk_val : rnd[23:0];
                                end
                        end
                end
                forever begin
                        @(posedge clk);
                        if (out_we === 1'b1)
                                mem[row][col] <= out_pix;
                end
        end

        initial begin
                wait_cycles = 0;
                while (finished !== 1'b1 && wait_cycles < run_limit) begin
                        @(posedge clk);
                        wait_cycles++;
                end
                if (finished !== 1'b1) begin
                        $display("The checker did not finish within %0d cycles", run_limit);
                        $display("Test failed");
                        $finish;
                end else begin
                        $display("Value errors: %0d, protocol errors: %0d, timeout: %0d",
                                 value_errors, protocol_errors, timed_out);
                        if (value_errors == 0 && protocol_errors == 0 && timed_out == 1'b0)
                                $display("Test passed");
                        else
                                $display("Test failed");
                        $finish;
                end
        end

endmodule

/* tests/image_checker.sv */
`timescale 1ns/1ps
`include "image_proc_defs.svh"

module image_checker (
        input  logic                   clk,
        input  logic                   rst_n,
        input  image_proc_pkg::coord_t row,
        input  image_proc_pkg::coord_t col,
        input  logic                   out_we,
        input  image_proc_pkg::rgb_t   out_pix,
        input  logic                   gray_done,
        input  logic                   compress_done,
        output logic                   finished,
        output logic                   timed_out,
        output int                     value_errors,
        output int                     protocol_errors
);
        import image_proc_pkg::*;

        // 16 cycles each for sum, dev and map, one calc cycle, 16 writes
        localparam int blk_cycles = 4 * `BLK_PIX + 1;
        localparam int n_blk      = (`IMG_DIM / `BLK_DIM) * (`IMG_DIM / `BLK_DIM);
        localparam int n_pix      = `IMG_DIM * `IMG_DIM;

        // expected green plane after the gray phase and after compression
        pix_t gray_exp [0:`IMG_DIM-1][0:`IMG_DIM-1];
        pix_t cmp_exp  [0:`IMG_DIM-1][0:`IMG_DIM-1];
        // set for each block whose gray values are all equal
        bit   uniform  [0:`IMG_DIM/`BLK_DIM-1][0:`IMG_DIM/`BLK_DIM-1];
        int   uniform_blocks;
        int   cycles;
        int   writes;
        int   streak;

        // gray is the floored mean of the largest and the smallest channel
        function automatic pix_t gray_of(input rgb_t p);
                int r;
                int g;
                int b;
                int mx;
                int mn;
                r  = int'(p[23:16]);
                g  = int'(p[15:8]);
                b  = int'(p[7:0]);
                mx = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
                mn = (r < g) ? ((r < b) ? r : b) : ((g < b) ? g : b);
                return pix_t'((mx + mn) / 2);
        endfunction

        // reference AMBTC over the gray plane in 4x4 blocks
        task automatic build_model();
                int sum;
                int dev;
                int beta;
                int avg;
                int var_v;
                int p;
                int high;
                int low;
                for (int r = 0; r < `IMG_DIM; r++)
                        for (int c = 0; c < `IMG_DIM; c++)
                                gray_exp[r][c] = gray_of(tb_image_proc.mem[r][c]);
                for (int br = 0; br < `IMG_DIM; br += `BLK_DIM) begin
                        for (int bc = 0; bc < `IMG_DIM; bc += `BLK_DIM) begin
                                sum  = 0;
                                dev  = 0;
                                beta = 0;
                                for (int i = 0; i < `BLK_PIX; i++)
                                        sum += int'(gray_exp[br + i / `BLK_DIM][bc + i % `BLK_DIM]);
                                avg = sum / `BLK_PIX;
                                for (int i = 0; i < `BLK_PIX; i++) begin
                                        p = int'(gray_exp[br + i / `BLK_DIM][bc + i % `BLK_DIM]);
                                        dev += (p >= avg) ? (p - avg) : (avg - p);
                                        if (p >= avg)
                                                beta++;
                                end
                                var_v = dev / `BLK_PIX;
                                // beta is at least 1 since the largest value is never below avg
                                high = avg + (16 * var_v) / (2 * beta);
                                if (beta == `BLK_PIX)
                                        low = avg;
                                else
                                        low = avg - (16 * var_v) / (2 * (`BLK_PIX - beta));
                                uniform[br / `BLK_DIM][bc / `BLK_DIM] = (dev == 0);
                                if (dev == 0)
                                        uniform_blocks++;
                                // the cast keeps the low 8 bits of each level
                                for (int i = 0; i < `BLK_PIX; i++) begin
                                        p = int'(gray_exp[br + i / `BLK_DIM][bc + i % `BLK_DIM]);
                                        cmp_exp[br + i / `BLK_DIM][bc + i % `BLK_DIM] =
                                                pix_t'((p >= avg) ? high : low);
                                end
                        end
                end
        endtask

        task automatic check_idle(input string when_txt);
                if (out_we !== 1'b0 || gray_done !== 1'b0 || compress_done !== 1'b0) begin
                        protocol_errors++;
                        $display("At %0t a write or done strobe was high %s", $time, when_txt);
                end
        endtask

        // counts one wrong pixel and prints where it was seen
        task automatic report_value(input string what, input int r, input int c,
                                    input rgb_t exp_pix, input rgb_t got);
                value_errors++;
                $display("Error at %0t: %s row %0d col %0d expected %h got %h",
                         $time, what, r, c, exp_pix, got);
        endtask

        // every memory pixel must hold red 0, the expected green and blue 0
        task automatic compare_memory(input bit compressed);
                rgb_t got;
                rgb_t exp_pix;
                for (int r = 0; r < `IMG_DIM; r++) begin
                        for (int c = 0; c < `IMG_DIM; c++) begin
                                got     = tb_image_proc.mem[r][c];
                                exp_pix = {8'h00, compressed ? cmp_exp[r][c] : gray_exp[r][c],
                                           8'h00};
                                if (got !== exp_pix)
                                        report_value("memory", r, c, exp_pix, got);
                                // a uniform block keeps its gray value whatever the levels say
                                if (compressed && uniform[r / `BLK_DIM][c / `BLK_DIM] &&
                                    got[15:8] !== gray_exp[r][c])
                                        report_value("uniform block", r, c,
                                                     rgb_t'(gray_exp[r][c]), rgb_t'(got[15:8]));
                        end
                end
        endtask

        // steps clock by clock until the strobe and checks each write by its row and col
        task automatic watch_phase(input bit compressed, input int limit, input string strobe);
                logic done_seen;
                logic wrong_done;
                rgb_t exp_pix;
                cycles    = 0;
                writes    = 0;
                streak    = 0;
                done_seen = 1'b0;
                while (!done_seen && !timed_out) begin
                        @(posedge clk);
                        cycles++;
                        done_seen  = compressed ? (compress_done === 1'b1) : (gray_done === 1'b1);
                        wrong_done = compressed ? (gray_done === 1'b1) : (compress_done === 1'b1);
                        if (wrong_done) begin
                                protocol_errors++;
                                $display("At %0t the other done strobe came before %s",
                                         $time, strobe);
                        end
                        if (!done_seen && out_we === 1'b1) begin
                                if (compressed)
                                        exp_pix = {8'h00, cmp_exp[row][col], 8'h00};
                                else
                                        exp_pix = {8'h00, gray_exp[row][col], 8'h00};
                                writes++;
                                if (out_pix !== exp_pix)
                                        report_value("write", row, col, exp_pix, out_pix);
                        end
                        // length of the run of writes that ends just before the strobe
                        if (!done_seen)
                                streak = (out_we === 1'b1) ? streak + 1 : 0;
                        if (!done_seen && cycles >= limit) begin
                                $display("Timeout: %s did not arrive within %0d cycles",
                                         strobe, limit);
                                timed_out = 1'b1;
                        end
                end
        endtask

        initial begin
                finished        = 1'b0;
                timed_out       = 1'b0;
                value_errors    = 0;
                protocol_errors = 0;
                uniform_blocks  = 0;
                // the image is complete by the first edge while reset is still held
                @(posedge clk);
                build_model();
                cycles = 0;
                while (rst_n !== 1'b1 && !timed_out) begin
                        check_idle("while reset was held");
                        cycles++;
                        if (cycles > 50) begin
                                $display("Timeout: reset was not released within 50 cycles");
                                timed_out = 1'b1;
                        end
                        @(posedge clk);
                end
                check_idle("in the first cycle after reset");
                if (row !== '0 || col !== '0) begin
                        protocol_errors++;
                        $display("Row and col were not both 0 after reset");
                end
                watch_phase(1'b0, n_pix + 100, "gray_done");
                if (!timed_out) begin
                        // the writes fill the first 4096 watched cycles and gray_done follows
                        if (cycles != n_pix + 1 || streak != n_pix || writes != n_pix) begin
                                protocol_errors++;
                                $display("gray_done after %0d cycles, %0d writes, %0d in one run",
                                         cycles, writes, streak);
                        end
                        compare_memory(1'b0);
                        watch_phase(1'b1, n_blk * blk_cycles + 100, "compress_done");
                end
                if (!timed_out) begin
                        if (cycles != n_blk * blk_cycles || writes != n_pix) begin
                                protocol_errors++;
                                $display("compress_done came after %0d cycles and %0d writes",
                                         cycles, writes);
                        end
                        compare_memory(1'b1);
                        if (uniform_blocks == 0) begin
                                protocol_errors++;
                                $display("The image held no uniform block to check");
                        end
                        // the design must stay quiet in finish
                        repeat (200) begin
                                @(posedge clk);
                                check_idle("after compress_done");
                        end
                end
                finished = 1'b1;
        end

endmodule

/* hw/image_proc_top.sv */
`timescale 1ns/1ps
`include "image_proc_defs.svh"

module image_proc_top (
        input  logic                   clk,
        input  logic                   rst_n,
        input  image_proc_pkg::rgb_t   in_pix,
        output image_proc_pkg::coord_t row,
        output image_proc_pkg::coord_t col,
        output logic                   out_we,
        output image_proc_pkg::rgb_t   out_pix,
        output logic                   gray_done,
        output logic                   compress_done
);
        import image_proc_pkg::*;

        phase_t   phase;
        pass_t    pass;
        logic     step;
        logic     raster;
        logic     blk_adv;
        logic     blk_end;
        logic     img_end;
        blk_pos_t blk_pos;
        pix_t     low;
        pix_t     high;
        bitmap_t  bitmap;

        // sequencer for the gray phase and the per-block passes
        proc_fsm i_proc_fsm (
                .clk           (clk),
                .rst_n         (rst_n),
                .blk_end       (blk_end),
                .img_end       (img_end),
                .phase         (phase),
                .pass          (pass),
                .step          (step),
                .raster        (raster),
                .blk_adv       (blk_adv),
                .out_we        (out_we),
                .gray_done     (gray_done),
                .compress_done (compress_done)
        );

        // row and col go straight to the memory, the read is combinational
        pixel_scanner i_pixel_scanner (
                .clk     (clk),
                .rst_n   (rst_n),
                .step    (step),
                .raster  (raster),
                .blk_adv (blk_adv),
                .row     (row),
                .col     (col),
                .blk_pos (blk_pos),
                .blk_end (blk_end),
                .img_end (img_end)
        );

        // in the compress phase the memory holds the gray image in green
        block_stats i_block_stats (
                .clk     (clk),
                .rst_n   (rst_n),
                .pass    (pass),
                .gray    (in_pix[2*`CH_W-1:`CH_W]),
                .blk_pos (blk_pos),
                .low     (low),
                .high    (high),
                .bitmap  (bitmap)
        );

        pixel_writer i_pixel_writer (
                .phase   (phase),
                .in_pix  (in_pix),
                .low     (low),
                .high    (high),
                .bitmap  (bitmap),
                .blk_pos (blk_pos),
                .out_pix (out_pix)
        );

endmodule

/* hw/pixel_writer.sv */
`timescale 1ns/1ps
`include "image_proc_defs.svh"

module pixel_writer (
        input  image_proc_pkg::phase_t   phase,
        input  image_proc_pkg::rgb_t     in_pix,
        input  image_proc_pkg::pix_t     low,
        input  image_proc_pkg::pix_t     high,
        input  image_proc_pkg::bitmap_t  bitmap,
        input  image_proc_pkg::blk_pos_t blk_pos,
        output image_proc_pkg::rgb_t     out_pix
);
        import image_proc_pkg::*;

        pix_t red;
        pix_t green;
        pix_t blue;
        pix_t ch_max;
        pix_t ch_min;
        pix_t gray_val;
        pix_t level;
        // one extra bit keeps the carry of max plus min
        logic [`CH_W:0] mid_sum;

        assign red   = in_pix[3*`CH_W-1:2*`CH_W];
        assign green = in_pix[2*`CH_W-1:`CH_W];
        assign blue  = in_pix[`CH_W-1:0];

        // largest and smallest of the three channels
        always_comb begin
                ch_max = red;
                if (green > ch_max)
                        ch_max = green;
                if (blue > ch_max)
                        ch_max = blue;
                ch_min = red;
                if (green < ch_min)
                        ch_min = green;
                if (blue < ch_min)
                        ch_min = blue;
        end

        assign mid_sum  = {1'b0, ch_max} + {1'b0, ch_min};
        assign gray_val = mid_sum[`CH_W:1];

        // the bitmap bit picks the quantizer level for this block pixel
        assign level = bitmap[blk_pos] ? high : low;

        // only green carries data, red and blue are written as 0
        assign out_pix = {{`CH_W{1'b0}}, (phase == ph_gray) ? gray_val : level, {`CH_W{1'b0}}};

endmodule

/* hw/block_stats.sv */
`timescale 1ns/1ps
`include "image_proc_defs.svh"

module block_stats (
        input  logic                     clk,
        input  logic                     rst_n,
        input  image_proc_pkg::pass_t    pass,
        input  image_proc_pkg::pix_t     gray,
        input  image_proc_pkg::blk_pos_t blk_pos,
        output image_proc_pkg::pix_t     low,
        output image_proc_pkg::pix_t     high,
        output image_proc_pkg::bitmap_t  bitmap
);
        import image_proc_pkg::*;

        acc_t               sum_q;
        acc_t               dev_q;
        logic [`BETA_W-1:0] beta_q;

        pix_t               avg;
        pix_t               var_val;
        pix_t               abs_dev;
        logic               at_or_above;
        acc_t               var_scaled;
        acc_t               hi_div;
        acc_t               lo_div;
        acc_t               hi_step;
        acc_t               lo_step;
        logic [`BETA_W-1:0] lo_cnt;

        // dividing by 16 is a drop of the low four bits
        assign avg     = sum_q[`ACC_W-1:`ACC_W-`CH_W];
        assign var_val = dev_q[`ACC_W-1:`ACC_W-`CH_W];

        assign at_or_above = (gray >= avg);
        assign abs_dev     = at_or_above ? (gray - avg) : (avg - gray);

        // high uses 16*var / (2*beta), low uses 16*var / (2*(16-beta))
        assign var_scaled = acc_t'(var_val) * acc_t'(`BLK_PIX);
        assign lo_cnt     = `BETA_W'(`BLK_PIX) - beta_q;
        // a zero count gives divisor 2 here, its quotient is never used
        assign hi_div     = (beta_q == '0) ? acc_t'(2) : acc_t'({beta_q, 1'b0});
        assign lo_div     = (lo_cnt == '0) ? acc_t'(2) : acc_t'({lo_cnt, 1'b0});
        assign hi_step    = var_scaled / hi_div;
        assign lo_step    = var_scaled / lo_div;

        // accumulators, cleared during write so the next block starts at zero
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sum_q  <= '0;
                        dev_q  <= '0;
                        beta_q <= '0;
                end else begin
                        case (pass)
                        pass_sum: begin
                                sum_q <= sum_q + acc_t'(gray);
                        end
                        pass_dev: begin
                                dev_q <= dev_q + acc_t'(abs_dev);
                        end
                        pass_map: begin
                                if (at_or_above)
                                        beta_q <= beta_q + 1'b1;
                        end
                        pass_write: begin
                                sum_q  <= '0;
                                dev_q  <= '0;
                                beta_q <= '0;
                        end
                        default: begin
                        end
                        endcase
                end
        end

        // the bitmap is rewritten in full by every map pass
        always_ff @(posedge clk) begin
                if (pass == pass_map)
                        bitmap[blk_pos] <= at_or_above;
        end

        // levels are truncated to 8 bits, adding the low byte of the step
        // gives the same result as the full sum modulo 256
        always_ff @(posedge clk) begin
                if (pass == pass_calc) begin
                        high <= avg + hi_step[`CH_W-1:0];
                        // a block with every pixel at or above avg keeps low at avg
                        if (lo_cnt == '0)
                                low <= avg;
                        else
                                low <= avg - lo_step[`CH_W-1:0];
                end
        end

endmodule

/* hw/pixel_scanner.sv */
`timescale 1ns/1ps
`include "image_proc_defs.svh"

module pixel_scanner (
        input  logic                     clk,
        input  logic                     rst_n,
        input  logic                     step,
        input  logic                     raster,
        input  logic                     blk_adv,
        output image_proc_pkg::coord_t   row,
        output image_proc_pkg::coord_t   col,
        output image_proc_pkg::blk_pos_t blk_pos,
        output logic                     blk_end,
        output logic                     img_end
);
        localparam logic [`COORD_W-1:0]   coord_last = `COORD_W'(`IMG_DIM - 1);
        localparam logic [`OFF_W-1:0]     off_last   = `OFF_W'(`BLK_DIM - 1);
        localparam logic [`BLK_IDX_W-1:0] blk_last   = `BLK_IDX_W'(`IMG_DIM / `BLK_DIM - 1);

        // the low bits of row and col are the offset inside the block,
        // the high bits are the block origin in block units
        logic [`OFF_W-1:0]     off_row;
        logic [`OFF_W-1:0]     off_col;
        logic [`BLK_IDX_W-1:0] blk_row;
        logic [`BLK_IDX_W-1:0] blk_col;

        assign off_row = row[`OFF_W-1:0];
        assign off_col = col[`OFF_W-1:0];
        assign blk_row = row[`COORD_W-1:`OFF_W];
        assign blk_col = col[`COORD_W-1:`OFF_W];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        row <= '0;
                        col <= '0;
                end else if (step) begin
                        if (raster) begin
                                // raster order, the column runs fastest
                                // and both wrap to block 0 at the end
                                col <= col + 1'b1;
                                if (col == coord_last)
                                        row <= row + 1'b1;
                        end else begin
                                // inside a block the offsets wrap to 0 after the last pixel
                                col[`OFF_W-1:0] <= off_col + 1'b1;
                                if (off_col == off_last)
                                        row[`OFF_W-1:0] <= off_row + 1'b1;
                                // blocks are visited row-major, block column first
                                if (blk_end && blk_adv) begin
                                        col[`COORD_W-1:`OFF_W] <= blk_col + 1'b1;
                                        if (blk_col == blk_last)
                                                row[`COORD_W-1:`OFF_W] <= blk_row + 1'b1;
                                end
                        end
                end
        end

        assign blk_pos = {off_row, off_col};
        assign blk_end = (off_row == off_last) && (off_col == off_last);
        // the last raster pixel and the last pixel of the last block coincide
        assign img_end = (row == coord_last) && (col == coord_last);

endmodule

/* hw/proc_fsm.sv */
`timescale 1ns/1ps

module proc_fsm (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   blk_end,
        input  logic                   img_end,
        output image_proc_pkg::phase_t phase,
        output image_proc_pkg::pass_t  pass,
        output logic                   step,
        output logic                   raster,
        output logic                   blk_adv,
        output logic                   out_we,
        output logic                   gray_done,
        output logic                   compress_done
);
        import image_proc_pkg::*;

        // low for the first cycle after reset so that nothing is written
        // while reset is held or right after its release
        logic run;

        // every scan step takes one cycle, the pass changes when the scanner
        // reports the last pixel of the block
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        run           <= 1'b0;
                        phase         <= ph_gray;
                        // write pass keeps the block accumulators cleared
                        pass          <= pass_write;
                        gray_done     <= 1'b0;
                        compress_done <= 1'b0;
                end else begin
                        run           <= 1'b1;
                        gray_done     <= 1'b0;
                        compress_done <= 1'b0;
                        case (phase)
                        ph_gray: begin
                                // the last raster pixel is written in this cycle
                                if (run && img_end) begin
                                        phase     <= ph_compress;
                                        pass      <= pass_sum;
                                        gray_done <= 1'b1;
                                end
                        end
                        ph_compress: begin
                                case (pass)
                                pass_sum: begin
                                        if (blk_end)
                                                pass <= pass_dev;
                                end
                                pass_dev: begin
                                        if (blk_end)
                                                pass <= pass_map;
                                end
                                pass_map: begin
                                        if (blk_end)
                                                pass <= pass_calc;
                                end
                                // calc is a single cycle with the scan held
                                pass_calc: begin
                                        pass <= pass_write;
                                end
                                pass_write: begin
                                        if (blk_end && img_end) begin
                                                phase         <= ph_finish;
                                                compress_done <= 1'b1;
                                        end else if (blk_end) begin
                                                pass <= pass_sum;
                                        end
                                end
                                default: begin
                                        pass <= pass_sum;
                                end
                                endcase
                        end
                        // finish is final, only a reset leaves it
                        default: begin
                        end
                        endcase
                end
        end

        assign raster  = (phase == ph_gray);
        // the block scan moves on only after the compressed block is written
        assign blk_adv = (phase == ph_compress) && (pass == pass_write);
        // the scan holds during calc and finish
        assign step    = run && (raster || ((phase == ph_compress) && (pass != pass_calc)));
        assign out_we  = run && (raster || blk_adv);

endmodule

/* hw/image_proc_pkg.sv */
`include "image_proc_defs.svh"

package image_proc_pkg;

        // one channel value, also used for gray levels
        typedef logic [`CH_W-1:0] pix_t;
        // red in the top byte, green in the middle, blue at the bottom
        typedef logic [3*`CH_W-1:0] rgb_t;
        typedef logic [`COORD_W-1:0] coord_t;
        // pixel index inside a block, row-major
        typedef logic [`BLK_POS_W-1:0] blk_pos_t;
        typedef logic [`ACC_W-1:0] acc_t;
        // one bit per block pixel, indexed by blk_pos_t
        typedef logic [`BLK_PIX-1:0] bitmap_t;

        // top-level phases of the job
        typedef enum logic [1:0] {ph_gray, ph_compress, ph_finish} phase_t;

        // passes run over every block during compression
        typedef enum logic [2:0] {
                pass_sum,
                pass_dev,
                pass_map,
                pass_calc,
                pass_write
        } pass_t;

endpackage

/* hw/image_proc_defs.svh */
`ifndef IMAGE_PROC_DEFS_SVH
`define IMAGE_PROC_DEFS_SVH

// the image is square, this is its side in pixels
`define IMG_DIM 64

// ambtc works on square blocks of this side
`define BLK_DIM 4
`define BLK_PIX 16

// width of one color channel
`define CH_W 8

// widths derived from the sizes above
`define COORD_W 6
`define OFF_W 2
`define BLK_IDX_W 4
`define BLK_POS_W 4
// a sum of 16 channel values needs 12 bits
`define ACC_W 12
// beta counts 0 to 16
`define BETA_W 5

`endif
